//--- hw/exu.sv
`timescale 1ns/100ps

module exu (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   dec_valid,
  output logic                   dec_ready,
  input  rv_pipe_pkg::dec_pkt_t  dec,
  output logic                   exe_valid,
  output rv_pipe_pkg::exe_pkt_t  exe,
  output rv_pipe_pkg::redirect_t redirect
);

  logic [31:0] a;
  logic [31:0] b;
  logic [4:0]  shamt;
  logic [31:0] alu_res;
  logic        taken;
  logic [31:0] pc4;
  logic [31:0] target;
  logic [31:0] next_pc;
  logic        accept;
  logic        redir_valid;
  logic [31:0] redir_pc;

  assign a     = dec.src1;
  assign b     = dec.src2;
  assign shamt = b[4:0];

  always_comb begin
    case (dec.alu_op)
      rv_isa_pkg::alu_imm:  alu_res = b;
      rv_isa_pkg::alu_add:  alu_res = a + b;
      rv_isa_pkg::alu_sub:  alu_res = a - b;
      rv_isa_pkg::alu_and:  alu_res = a & b;
      rv_isa_pkg::alu_xor:  alu_res = a ^ b;
      rv_isa_pkg::alu_or:   alu_res = a | b;
      rv_isa_pkg::alu_sl:   alu_res = a << shamt;
      rv_isa_pkg::alu_sr:   alu_res = a >> shamt;
      rv_isa_pkg::alu_ssr:  alu_res = $unsigned($signed(a) >>> shamt);
      rv_isa_pkg::alu_sles: alu_res = {31'd0, $signed(a) < $signed(b)};
      rv_isa_pkg::alu_ules: alu_res = {31'd0, a < b};
      default:              alu_res = 32'd0;
    endcase
  end

  // branches compare the two register operands
  always_comb begin
    case (dec.br_op)
      rv_isa_pkg::br_eq:   taken = (a == b);
      rv_isa_pkg::br_ne:   taken = (a != b);
      rv_isa_pkg::br_lt:   taken = ($signed(a) < $signed(b));
      rv_isa_pkg::br_ge:   taken = ($signed(a) >= $signed(b));
      rv_isa_pkg::br_ltu:  taken = (a < b);
      rv_isa_pkg::br_geu:  taken = (a >= b);
      rv_isa_pkg::br_jump: taken = 1'b1;
      default:             taken = 1'b0;
    endcase
  end

  assign pc4 = dec.pc + 32'd4;

  // jump target is the alu sum with bit 0 cleared
  assign target  = (dec.br_op == rv_isa_pkg::br_jump) ? {alu_res[31:1], 1'b0}
                                                     : dec.pc + dec.imm;
  assign next_pc = taken ? target : pc4;

  assign dec_ready = !exe_valid;
  assign accept    = dec_valid & dec_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exe_valid   <= 1'b0;
      redir_valid <= 1'b0;
    end else begin
      exe_valid   <= accept;        // result stage never stalls
      redir_valid <= accept & ~dec.halt;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      exe.pc   <= dec.pc;
      exe.rd   <= dec.rd;
      exe.we   <= dec.we;
      exe.wd   <= (dec.wd_sel == rv_isa_pkg::wd_pc4) ? pc4 : alu_res;
      exe.halt <= dec.halt;
      redir_pc <= next_pc;
    end
  end

  assign redirect.valid = redir_valid;
  assign redirect.pc    = redir_pc;

endmodule

//--- hw/idu.sv
`timescale 1ns/100ps

module idu (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    fetch_valid,
  output logic                    fetch_ready,
  input  rv_pipe_pkg::fetch_pkt_t fetch,
  output logic [4:0]              rs1,
  output logic [4:0]              rs2,
  input  logic [31:0]             rs1_data,
  input  logic [31:0]             rs2_data,
  output logic                    dec_valid,
  input  logic                    dec_ready,
  output rv_pipe_pkg::dec_pkt_t   dec
);

  rv_isa_pkg::inst_u     ins;
  logic [31:0]           imm_i;
  logic [31:0]           imm_b;
  logic [31:0]           imm_u;
  logic [31:0]           imm_j;
  rv_pipe_pkg::dec_pkt_t nxt;

  function automatic rv_isa_pkg::alu_op_e alu_fn(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  alu_fn = alt ? rv_isa_pkg::alu_sub : rv_isa_pkg::alu_add;
      3'b001:  alu_fn = rv_isa_pkg::alu_sl;
      3'b010:  alu_fn = rv_isa_pkg::alu_sles;
      3'b011:  alu_fn = rv_isa_pkg::alu_ules;
      3'b100:  alu_fn = rv_isa_pkg::alu_xor;
      3'b101:  alu_fn = alt ? rv_isa_pkg::alu_ssr : rv_isa_pkg::alu_sr;
      3'b110:  alu_fn = rv_isa_pkg::alu_or;
      default: alu_fn = rv_isa_pkg::alu_and;
    endcase
  endfunction

  assign ins = fetch.inst;
  assign rs1 = ins.r.rs1;
  assign rs2 = ins.r.rs2;

  assign imm_i = {{20{ins.i.imm_11_0[11]}}, ins.i.imm_11_0};
  assign imm_b = {{20{ins.b.imm_12}}, ins.b.imm_11, ins.b.imm_10_5, ins.b.imm_4_1, 1'b0};
  assign imm_u = {ins.u.imm_31_12, 12'd0};
  assign imm_j = {{12{ins.j.imm_20}}, ins.j.imm_19_12, ins.j.imm_11, ins.j.imm_10_1, 1'b0};

  always_comb begin
    nxt        = '0;              // unknown opcode ends up as a nop
    nxt.pc     = fetch.pc;
    nxt.alu_op = rv_isa_pkg::alu_add;
    nxt.br_op  = rv_isa_pkg::br_none;
    nxt.wd_sel = rv_isa_pkg::wd_none;
    nxt.rd     = ins.r.rd;
    case (ins.r.opcode)
      rv_isa_pkg::opc_op: begin
        nxt.src1   = rs1_data;
        nxt.src2   = rs2_data;
        nxt.alu_op = alu_fn(ins.r.funct3, ins.r.funct7[5]);
        nxt.wd_sel = rv_isa_pkg::wd_alu;
      end
      rv_isa_pkg::opc_op_imm: begin
        nxt.src1   = rs1_data;
        nxt.src2   = imm_i;
        nxt.imm    = imm_i;
        // bit 30 is an immediate bit except for srai
        nxt.alu_op = alu_fn(ins.r.funct3, (ins.r.funct3 == 3'b101) & ins.r.funct7[5]);
        nxt.wd_sel = rv_isa_pkg::wd_alu;
      end
      rv_isa_pkg::opc_lui: begin
        nxt.src2   = imm_u;
        nxt.imm    = imm_u;
        nxt.alu_op = rv_isa_pkg::alu_imm;
        nxt.wd_sel = rv_isa_pkg::wd_alu;
      end
      rv_isa_pkg::opc_auipc: begin
        nxt.src1   = fetch.pc;
        nxt.src2   = imm_u;
        nxt.imm    = imm_u;
        nxt.wd_sel = rv_isa_pkg::wd_alu;
      end
      rv_isa_pkg::opc_jal: begin
        nxt.src1   = fetch.pc;
        nxt.src2   = imm_j;
        nxt.imm    = imm_j;
        nxt.br_op  = rv_isa_pkg::br_jump;
        nxt.wd_sel = rv_isa_pkg::wd_pc4;
      end
      rv_isa_pkg::opc_jalr: begin
        nxt.src1   = rs1_data;
        nxt.src2   = imm_i;
        nxt.imm    = imm_i;
        nxt.br_op  = rv_isa_pkg::br_jump;
        nxt.wd_sel = rv_isa_pkg::wd_pc4;
      end
      rv_isa_pkg::opc_branch: begin
        nxt.src1 = rs1_data;
        nxt.src2 = rs2_data;
        nxt.imm  = imm_b;
        case (ins.b.funct3)
          3'b000:  nxt.br_op = rv_isa_pkg::br_eq;
          3'b001:  nxt.br_op = rv_isa_pkg::br_ne;
          3'b100:  nxt.br_op = rv_isa_pkg::br_lt;
          3'b101:  nxt.br_op = rv_isa_pkg::br_ge;
          3'b110:  nxt.br_op = rv_isa_pkg::br_ltu;
          3'b111:  nxt.br_op = rv_isa_pkg::br_geu;
          default: nxt.br_op = rv_isa_pkg::br_none;
        endcase
      end
      rv_isa_pkg::opc_system: begin
        nxt.halt = (fetch.inst == rv_isa_pkg::ebreak_word);  // ecall falls through as nop
      end
      default: ;
    endcase
    nxt.we = (nxt.wd_sel != rv_isa_pkg::wd_none);
  end

  assign fetch_ready = !dec_valid;  // one instruction at a time

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec_valid <= 1'b0;
    end else if (fetch_valid && fetch_ready) begin
      dec_valid <= 1'b1;
    end else if (dec_ready) begin
      dec_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_valid && fetch_ready) dec <= nxt;
  end

endmodule

//--- hw/ifu.sv
`timescale 1ns/100ps

module ifu (
  input  logic                    clk,
  input  logic                    rst_n,
  output logic                    imem_req_valid,
  output logic [31:0]             imem_addr,
  input  logic                    imem_req_ready,
  input  logic                    imem_rsp_valid,
  input  logic [31:0]             imem_rdata,
  input  rv_pipe_pkg::redirect_t  redirect,
  output logic                    fetch_valid,
  input  logic                    fetch_ready,
  output rv_pipe_pkg::fetch_pkt_t fetch
);

  typedef enum logic [1:0] {st_req, st_rsp, st_hold} state_e;

  state_e                  state;
  logic                    boot;        // kicks off the first request
  logic [31:0]             pc;
  logic                    hold_valid;  // word waiting for decode
  rv_pipe_pkg::fetch_pkt_t hold_pkt;

  assign imem_req_valid = (state == st_req);
  assign imem_addr      = pc;

  // decode takes the response directly unless it is still busy
  assign fetch_valid = hold_valid | ((state == st_rsp) & imem_rsp_valid);

  always_comb begin
    fetch = hold_pkt;
    if (!hold_valid) begin
      fetch.pc   = pc;
      fetch.inst = imem_rdata;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= st_hold;
      boot       <= 1'b1;
      pc         <= rv_isa_pkg::reset_pc;
      hold_valid <= 1'b0;
    end else begin
      boot <= 1'b0;
      case (state)
        st_req: begin
          if (imem_req_ready) state <= st_rsp;
        end
        st_rsp: begin
          if (imem_rsp_valid) begin
            state      <= st_hold;
            hold_valid <= !fetch_ready;
          end
        end
        default: begin
          if (hold_valid && fetch_ready) hold_valid <= 1'b0;
          if (boot) begin
            state <= st_req;
          end else if (redirect.valid) begin
            pc    <= redirect.pc;  // next pc from execute
            state <= st_req;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == st_rsp) && imem_rsp_valid) begin
      hold_pkt.pc   <= pc;
      hold_pkt.inst <= imem_rdata;
    end
  end

endmodule

//--- hw/rv_core.sv
`timescale 1ns/100ps

module rv_core (
  input  logic                 clk,
  input  logic                 rst_n,
  output logic                 imem_req_valid,
  output logic [31:0]          imem_addr,
  input  logic                 imem_req_ready,
  input  logic                 imem_rsp_valid,
  input  logic [31:0]          imem_rdata,
  output rv_pipe_pkg::retire_t retire,
  output logic                 halted
);

  logic                    fetch_valid;
  logic                    fetch_ready;
  rv_pipe_pkg::fetch_pkt_t fetch;
  logic                    dec_valid;
  logic                    dec_ready;
  rv_pipe_pkg::dec_pkt_t   dec;
  logic                    exe_valid;
  rv_pipe_pkg::exe_pkt_t   exe;
  rv_pipe_pkg::redirect_t  redirect;
  logic [4:0]              rs1;
  logic [4:0]              rs2;
  logic [31:0]             rs1_data;
  logic [31:0]             rs2_data;

  // instruction fetch
  ifu ifu_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .imem_req_valid (imem_req_valid),
    .imem_addr      (imem_addr),
    .imem_req_ready (imem_req_ready),
    .imem_rsp_valid (imem_rsp_valid),
    .imem_rdata     (imem_rdata),
    .redirect       (redirect),
    .fetch_valid    (fetch_valid),
    .fetch_ready    (fetch_ready),
    .fetch          (fetch)
  );

  idu idu_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_valid (fetch_valid),
    .fetch_ready (fetch_ready),
    .fetch       (fetch),
    .rs1         (rs1),
    .rs2         (rs2),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .dec_valid   (dec_valid),
    .dec_ready   (dec_ready),
    .dec         (dec)
  );

  exu exu_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .dec_valid (dec_valid),
    .dec_ready (dec_ready),
    .dec       (dec),
    .exe_valid (exe_valid),
    .exe       (exe),
    .redirect  (redirect)
  );

  // register array and retire
  wbu wbu_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .exe_valid (exe_valid),
    .exe       (exe),
    .rs1       (rs1),
    .rs2       (rs2),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .retire    (retire),
    .halted    (halted)
  );

endmodule

//--- hw/rv_isa_pkg.sv
package rv_isa_pkg;

  localparam logic [31:0] reset_pc = 32'h8000_0000;

  // major opcodes
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_system = 7'b1110011;

  localparam logic [31:0] ebreak_word = 32'h0010_0073;

  typedef enum logic [4:0] {
    alu_imm  = 5'd0,   // pass src2
    alu_add  = 5'd1,
    alu_sub  = 5'd2,
    alu_and  = 5'd3,
    alu_xor  = 5'd4,
    alu_or   = 5'd5,
    alu_sl   = 5'd6,
    alu_sr   = 5'd7,   // logical
    alu_ssr  = 5'd9,   // arithmetic
    alu_sles = 5'd10,  // signed less than
    alu_ules = 5'd11   // unsigned less than
  } alu_op_e;

  typedef enum logic [2:0] {
    br_none, br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu, br_jump
  } br_op_e;

  typedef enum logic [1:0] {
    wd_alu, wd_pc4, wd_none
  } wd_sel_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } inst_u;

endpackage

//--- hw/rv_pipe_pkg.sv
package rv_pipe_pkg;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
  } fetch_pkt_t;

  typedef struct packed {
    logic [31:0]         pc;
    logic [31:0]         src1;
    logic [31:0]         src2;
    logic [31:0]         imm;     // branch and jump offset
    rv_isa_pkg::alu_op_e alu_op;
    rv_isa_pkg::br_op_e  br_op;
    rv_isa_pkg::wd_sel_e wd_sel;
    logic [4:0]          rd;
    logic                we;
    logic                halt;
  } dec_pkt_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  rd;
    logic        we;
    logic [31:0] wd;
    logic        halt;
  } exe_pkt_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
  } redirect_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [4:0]  rd;
    logic        we;
    logic [31:0] wd;
  } retire_t;

endpackage

//--- hw/wbu.sv
`timescale 1ns/100ps

module wbu (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  exe_valid,
  input  rv_pipe_pkg::exe_pkt_t exe,
  input  logic [4:0]            rs1,
  input  logic [4:0]            rs2,
  output logic [31:0]           rs1_data,
  output logic [31:0]           rs2_data,
  output rv_pipe_pkg::retire_t  retire,
  output logic                  halted
);

  logic [31:0] rf [1:31];  // x0 not stored
  logic        exe_ready;
  logic        accept;
  logic        we_eff;

  assign exe_ready = 1'b1;
  assign accept    = exe_valid & exe_ready;
  assign we_eff    = exe.we & (exe.rd != 5'd0);

  assign rs1_data = (rs1 == 5'd0) ? 32'd0 : rf[rs1];
  assign rs2_data = (rs2 == 5'd0) ? 32'd0 : rf[rs2];

  always_ff @(posedge clk) begin
    if (accept && we_eff) rf[exe.rd] <= exe.wd;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      retire <= '0;
      halted <= 1'b0;
    end else begin
      retire.valid <= accept;  // one cycle strobe
      if (accept) begin
        retire.pc <= exe.pc;
        retire.rd <= exe.rd;
        retire.we <= we_eff;
        retire.wd <= exe.wd;
      end
      if (accept && exe.halt) halted <= 1'b1;
    end
  end

endmodule

//--- run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root
set -u

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

if ! verilator --binary --timing --assert -j 0 -f vlog.f --top-module rv_core_tb; then
  echo "verilator build failed"
  exit 1
fi

output="$(./obj_dir/Vrv_core_tb 2>&1)"
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "ALL TESTS PASSED"; then
  exit 0
else
  exit 1
fi

//--- sim/prog.hex
// one instruction word per line, the first at 0x8000_0000
// columns: hex word, then byte offset and the instruction it encodes
800000b7  // 00 lui   x1, 0x80000
ffb00113  // 04 addi  x2, x0, -5
00700193  // 08 addi  x3, x0, 7
00310233  // 0c add   x4, x2, x3
402182b3  // 10 sub   x5, x3, x2
00312333  // 14 slt   x6, x2, x3
003133b3  // 18 sltu  x7, x2, x3
4030d433  // 1c sra   x8, x1, x3
0030d4b3  // 20 srl   x9, x1, x3
00319533  // 24 sll   x10, x3, x3
003145b3  // 28 xor   x11, x2, x3
00a2e633  // 2c or    x12, x5, x10
0055f6b3  // 30 and   x13, x11, x5
00518013  // 34 addi  x0, x3, 5
00300733  // 38 add   x14, x0, x3
40115793  // 3c srai  x15, x2, 1
fff12813  // 40 slti  x16, x2, -1
00001997  // 44 auipc x19, 0x1
00e18463  // 48 beq   x3, x14, +8   taken
00100a13  // 4c addi  x20, x0, 1    skipped
00e19463  // 50 bne   x3, x14, +8   not taken
00314463  // 54 blt   x2, x3, +8    taken
00200a13  // 58 addi  x20, x0, 2    skipped
00315463  // 5c bge   x2, x3, +8    not taken
00316463  // 60 bltu  x2, x3, +8    not taken
00317463  // 64 bgeu  x2, x3, +8    taken
00300a13  // 68 addi  x20, x0, 3    skipped
00800aef  // 6c jal   x21, +8
00400a13  // 70 addi  x20, x0, 4    skipped
00da8b67  // 74 jalr  x22, 13(x21)
00500a13  // 78 addi  x20, x0, 5    skipped
fe21cce3  // 7c blt   x3, x2, -8    not taken
015b0bb3  // 80 add   x23, x22, x21
40208033  // 84 sub   x0, x1, x2
00006c33  // 88 or    x24, x0, x0
00100073  // 8c ebreak

//--- sim/rv_core_tb.sv
`timescale 1ns/100ps

module rv_core_tb;

  localparam int prog_retires   = 31;  // instructions on the program path
  localparam int timeout_cycles = 800;

  logic                 clk;
  logic                 rst_n          = 1'b0;
  logic                 imem_req_valid;
  logic [31:0]          imem_addr;
  logic                 imem_req_ready = 1'b0;
  logic                 imem_rsp_valid = 1'b0;
  logic [31:0]          imem_rdata     = 32'd0;
  rv_pipe_pkg::retire_t retire;
  logic                 halted;

  logic [31:0] mem [0:63];
  logic [31:0] lfsr      = 32'hd9d8_1cb5;
  logic        pend      = 1'b0;
  logic [2:0]  wait_cnt  = 3'd0;
  logic [31:0] pend_addr = 32'd0;
  logic        outstanding;
  int          cycles    = 0;

  logic [31:0]       model_x [0:31];
  logic [31:0]       model_pc;
  logic              model_halted;
  int                retired;
  rv_isa_pkg::inst_u ins;
  logic [31:0]       a;
  logic [31:0]       b;
  logic [31:0]       imm_i;
  logic [31:0]       imm_b;
  logic [31:0]       imm_u;
  logic [31:0]       imm_j;
  logic              writes;
  logic [4:0]        exp_rd;
  logic              exp_we;
  logic [31:0]       exp_wd;
  logic [31:0]       exp_npc;
  logic              exp_halt;

  tb_clock clock_i (
    .clk (clk)
  );

  rv_core dut_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .imem_req_valid (imem_req_valid),
    .imem_addr      (imem_addr),
    .imem_req_ready (imem_req_ready),
    .imem_rsp_valid (imem_rsp_valid),
    .imem_rdata     (imem_rdata),
    .retire         (retire),
    .halted         (halted)
  );

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(output logic [1:0] v);
    v = 2'd0;
    repeat (2) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[0], lfsr[0]};
    end
  endtask

  function automatic logic [5:0] word_index(input logic [31:0] addr);
    logic [31:0] off;
    off = addr - rv_isa_pkg::reset_pc;
    return off[7:2];
  endfunction

  function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] x, input logic [31:0] y);
    case (f3)
      3'd0:    return alt ? x - y : x + y;
      3'd1:    return x << y[4:0];
      3'd2:    return {31'd0, $signed(x) < $signed(y)};
      3'd3:    return {31'd0, x < y};
      3'd4:    return x ^ y;
      3'd5:    return alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
      3'd6:    return x | y;
      default: return x & y;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] x,
                                        input logic [31:0] y);
    case (f3)
      3'd0:    return x == y;
      3'd1:    return x != y;
      3'd4:    return $signed(x) < $signed(y);
      3'd5:    return $signed(x) >= $signed(y);
      3'd6:    return x < y;
      3'd7:    return x >= y;
      default: return 1'b0;
    endcase
  endfunction

  // memory model serving one request at a time
  always @(negedge clk) begin
    logic [1:0] r;
    if (rst_n) begin
      imem_rsp_valid <= 1'b0;
      imem_req_ready <= 1'b0;
      if (pend) begin
        if (wait_cnt == 3'd1) begin
          imem_rsp_valid <= 1'b1;
          imem_rdata     <= mem[word_index(pend_addr)];
          pend           <= 1'b0;
        end else begin
          wait_cnt <= wait_cnt - 3'd1;
        end
      end else if (imem_req_valid) begin
        draw_bits(r);
        if (r != 2'd0) begin  // stall one cycle in four
          draw_bits(r);
          imem_req_ready <= 1'b1;
          pend           <= 1'b1;
          wait_cnt       <= {1'b0, r} + 3'd1;
          pend_addr      <= imem_addr;
        end
      end
    end
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) outstanding <= 1'b0;
    else if (imem_req_valid && imem_req_ready) outstanding <= 1'b1;
    else if (imem_rsp_valid) outstanding <= 1'b0;
  end

  // reference model decodes the word at model_pc
  always_comb begin
    ins      = mem[word_index(model_pc)];
    a        = model_x[ins.r.rs1];
    b        = model_x[ins.r.rs2];
    imm_i    = {{20{ins[31]}}, ins[31:20]};
    imm_b    = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_u    = {ins[31:12], 12'd0};
    imm_j    = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    exp_rd   = ins.r.rd;
    exp_wd   = 32'd0;
    exp_npc  = model_pc + 32'd4;
    exp_halt = 1'b0;
    writes   = 1'b0;
    case (ins.r.opcode)
      rv_isa_pkg::opc_op: begin
        writes = 1'b1;
        exp_wd = ref_alu(ins.r.funct3, ins[30], a, b);
      end
      rv_isa_pkg::opc_op_imm: begin
        writes = 1'b1;
        exp_wd = ref_alu(ins.r.funct3, (ins.r.funct3 == 3'd5) && ins[30], a, imm_i);
      end
      rv_isa_pkg::opc_lui: begin
        writes = 1'b1;
        exp_wd = imm_u;
      end
      rv_isa_pkg::opc_auipc: begin
        writes = 1'b1;
        exp_wd = model_pc + imm_u;
      end
      rv_isa_pkg::opc_jal: begin
        writes  = 1'b1;
        exp_wd  = model_pc + 32'd4;
        exp_npc = model_pc + imm_j;
      end
      rv_isa_pkg::opc_jalr: begin
        writes  = 1'b1;
        exp_wd  = model_pc + 32'd4;
        exp_npc = (a + imm_i) & ~32'd1;
      end
      rv_isa_pkg::opc_branch: begin
        if (branch_taken(ins.r.funct3, a, b)) exp_npc = model_pc + imm_b;
      end
      rv_isa_pkg::opc_system: exp_halt = (ins == 32'h0010_0073);  // ebreak
      default: ;
    endcase
    exp_we = writes && (exp_rd != 5'd0);
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) model_x[i] <= 32'd0;
      model_pc     <= rv_isa_pkg::reset_pc;
      model_halted <= 1'b0;
      retired      <= 0;
    end else if (retire.valid) begin
      if (exp_we) model_x[exp_rd] <= exp_wd;
      model_pc <= exp_npc;
      retired  <= retired + 1;
      if (exp_halt) model_halted <= 1'b1;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) retire.valid |-> retire.pc == model_pc)
    else stop_on_error($sformatf("mismatch at %0t: retire pc %h, model pc %h",
                                 $time, $sampled(retire.pc), $sampled(model_pc)));

  assert property (@(posedge clk) disable iff (!rst_n) retire.valid |-> retire.we == exp_we)
    else stop_on_error($sformatf("mismatch at %0t: write enable at pc %h", $time,
                                 $sampled(model_pc)));

  assert property (@(posedge clk) disable iff (!rst_n)
                   retire.valid && exp_we |-> retire.rd == exp_rd && retire.wd == exp_wd)
    else stop_on_error($sformatf("mismatch at %0t: x%0d expected %h, got %h", $time,
                                 $sampled(exp_rd), $sampled(exp_wd), $sampled(retire.wd)));

  // the next fetch address follows the model even in the retire cycle
  assert property (@(posedge clk) disable iff (!rst_n)
                   imem_req_valid |-> imem_addr == (retire.valid ? exp_npc : model_pc))
    else stop_on_error($sformatf("mismatch at %0t: fetch address %h", $time,
                                 $sampled(imem_addr)));

  assert property (@(posedge clk) disable iff (!rst_n)
                   $past(imem_req_valid && !imem_req_ready)
                   |-> imem_req_valid && imem_addr == $past(imem_addr))
    else stop_on_error($sformatf("mismatch at %0t: stalled request changed", $time));

  assert property (@(posedge clk) disable iff (!rst_n) outstanding |-> !imem_req_valid)
    else stop_on_error("second fetch request issued before the response arrived");

  assert property (@(posedge clk) disable iff (!rst_n) retire.valid && exp_halt |-> halted)
    else stop_on_error($sformatf("mismatch at %0t: halted low after ebreak", $time));

  assert property (@(posedge clk) disable iff (!rst_n)
                   halted |-> model_halted || (retire.valid && exp_halt))
    else stop_on_error($sformatf("mismatch at %0t: halted rose early", $time));

  assert property (@(posedge clk) disable iff (!rst_n) halted |-> !imem_req_valid)
    else stop_on_error("fetch request issued after the core halted");

  assert property (@(posedge clk) disable iff (!rst_n) model_halted |-> !retire.valid)
    else stop_on_error("instruction retired after ebreak");

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles == timeout_cycles) stop_on_error("timeout, core did not halt in time");
  end

  initial begin
    $readmemh("sim/prog.hex", mem);
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n <= 1'b1;
    wait (halted);
    repeat (20) @(negedge clk);  // watch for fetches after the halt
    if (model_halted && retired == prog_retires) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      stop_on_error($sformatf("retired %0d instructions, expected %0d", retired,
                              prog_retires));
    end
  end

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

endmodule

//--- vlog.f
hw/rv_isa_pkg.sv
hw/rv_pipe_pkg.sv
hw/ifu.sv
hw/idu.sv
hw/exu.sv
hw/wbu.sv
hw/rv_core.sv
sim/tb_clock.sv
sim/rv_core_tb.sv
